// File: src/cipher_output.sv
`timescale 1ns/1ns
`default_nettype none

module cipher_output (
    input  wire                 CLOCK_50,
    input  wire                 i_rst_n,
    input  wire                 i_make,
    input  wire enigma_pkg::letter_t i_fwd_end,
    input  wire enigma_pkg::letter_t i_bwd_end,
    output enigma_pkg::letter_t o_reflected,
    output enigma_pkg::ascii_t  o_cipher,
    output logic                o_cipher_valid
);

    // turnaround between the forward and backward passes
    assign o_reflected = enigma_pkg::REFLECTOR_B[i_fwd_end];

    ////////////////////////////////////////////////////////////
    // ciphertext register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cipher       <= '0;
            o_cipher_valid <= 1'b0;
        end else if (i_make) begin
            // letter index to upper case
            o_cipher       <= enigma_pkg::ascii_t'(i_bwd_end) + enigma_pkg::ASCII_A;
            o_cipher_valid <= 1'b1;
        end else begin
            // cleared once the key leaves the make phase
            o_cipher       <= '0;
            o_cipher_valid <= 1'b0;
        end
    end

    // rotors are bijections, so a reflector without fixed points
    // on the sampled cycle keeps the ciphertext off the typed letter
    a_no_self_cipher: assert property (
        @(posedge CLOCK_50) disable iff (!i_rst_n)
        o_cipher_valid |-> $past(o_reflected != i_fwd_end)
    );

endmodule

`default_nettype wire

// File: src/enigma_pkg.sv
`default_nettype none

package enigma_pkg;

    ////////////////////////////////////////////////////////////
    // cipher-side types and sizes
    ////////////////////////////////////////////////////////////

    // letter index, 0 is A and 25 is Z
    typedef logic [4:0] letter_t;

    // ciphertext character
    typedef logic [7:0] ascii_t;

    localparam int NUM_ROTORS = 3;
    localparam int ALPHABET_SIZE = 26;
    localparam ascii_t ASCII_A = 8'h41;

    ////////////////////////////////////////////////////////////
    // wiring tables, index 0 is rotor I, 1 is II, 2 is III
    ////////////////////////////////////////////////////////////

    // contact i on the entry side goes to the listed letter
    localparam letter_t ROTOR_WIRING [NUM_ROTORS][ALPHABET_SIZE] = '{
        // I   EKMFLGDQVZNTOWYHXUSPAIBRCJ
        '{ 4, 10, 12,  5, 11,  6,  3, 16, 21, 25, 13, 19, 14,
          22, 24,  7, 23, 20, 18, 15,  0,  8,  1, 17,  2,  9},
        // II  AJDKSIRUXBLHWTMCQGZNPYFVOE
        '{ 0,  9,  3, 10, 18,  8, 17, 20, 23,  1, 11,  7, 22,
          19, 12,  2, 16,  6, 25, 13, 15, 24,  5, 21, 14,  4},
        // III BDFHJLCPRTXVZNYEIWGAKMUSQO
        '{ 1,  3,  5,  7,  9, 11,  2, 15, 17, 19, 23, 21, 25,
          13, 24,  4,  8, 22,  6,  0, 10, 12, 20, 18, 16, 14}
    };

    // position at which the next rotor to the left is carried
    // Q, E, V
    localparam letter_t ROTOR_NOTCH [NUM_ROTORS] = '{16, 4, 21};

    // reflector B, YRUHQSLDPXNGOKMIEBFZCWVJAT
    // no letter maps to itself
    localparam letter_t REFLECTOR_B [ALPHABET_SIZE] = '{
        24, 17, 20,  7, 16, 18, 11,  3, 15, 23, 13,  6, 14,
        10, 12,  8,  4,  1,  5, 25,  2, 22, 21,  9,  0, 19
    };

endpackage

`default_nettype wire

// File: src/enigma_top.sv
`timescale 1ns/1ns
`default_nettype none

module enigma_top (
    input  wire                              CLOCK_50,
    input  wire                              i_rst_n,
    input  wire kbd_pkg::scan_code_t         i_scan_code,
    input  wire                              i_scan_strobe,
    input  wire [enigma_pkg::NUM_ROTORS-1:0] i_set_sel,
    input  wire enigma_pkg::letter_t         i_set_letter,
    input  wire                              i_load_n,
    output enigma_pkg::ascii_t               o_cipher,
    output logic                             o_cipher_valid,
    output enigma_pkg::letter_t              o_rotor_pos_0,
    output enigma_pkg::letter_t              o_rotor_pos_1,
    output enigma_pkg::letter_t              o_rotor_pos_2
);

    // chain index 0 is the keyboard side, NUM_ROTORS the reflector side
    wire enigma_pkg::letter_t fwd_chain [enigma_pkg::NUM_ROTORS+1];
    wire enigma_pkg::letter_t bwd_chain [enigma_pkg::NUM_ROTORS+1];
    wire enigma_pkg::letter_t rotor_pos [enigma_pkg::NUM_ROTORS];
    // step into each rotor, top bit is the unused leftmost carry
    wire [enigma_pkg::NUM_ROTORS:0]   step_chain;
    wire [enigma_pkg::NUM_ROTORS-1:0] load_en;
    wire enigma_pkg::letter_t         load_letter;
    wire                              make;

    key_event_fsm key_event_fsm_i (
        .CLOCK_50      (CLOCK_50),
        .i_rst_n       (i_rst_n),
        .i_scan_code   (i_scan_code),
        .i_scan_strobe (i_scan_strobe),
        .o_letter      (fwd_chain[0]),
        .o_make        (make),
        .o_step        (step_chain[0])
    );

    setting_sync setting_sync_i (
        .CLOCK_50      (CLOCK_50),
        .i_rst_n       (i_rst_n),
        .i_set_sel     (i_set_sel),
        .i_set_letter  (i_set_letter),
        .i_load_n      (i_load_n),
        .o_load_en     (load_en),
        .o_load_letter (load_letter)
    );

    ////////////////////////////////////////////////////////////
    // rotors, stage 0 is rotor III on the right
    ////////////////////////////////////////////////////////////
    for (genvar k = 0; k < enigma_pkg::NUM_ROTORS; k++) begin : g_rotor
        rotor_stage #(
            .ROTOR_ID (enigma_pkg::NUM_ROTORS - 1 - k)
        ) rotor_stage_i (
            .CLOCK_50      (CLOCK_50),
            .i_rst_n       (i_rst_n),
            .i_step        (step_chain[k]),
            .i_load_en     (load_en[k]),
            .i_load_letter (load_letter),
            .i_fwd         (fwd_chain[k]),
            .i_bwd         (bwd_chain[k+1]),
            .o_fwd         (fwd_chain[k+1]),
            .o_bwd         (bwd_chain[k]),
            .o_carry       (step_chain[k+1]),
            .o_pos         (rotor_pos[k])
        );
    end

    cipher_output cipher_output_i (
        .CLOCK_50       (CLOCK_50),
        .i_rst_n        (i_rst_n),
        .i_make         (make),
        .i_fwd_end      (fwd_chain[enigma_pkg::NUM_ROTORS]),
        .i_bwd_end      (bwd_chain[0]),
        .o_reflected    (bwd_chain[enigma_pkg::NUM_ROTORS]),
        .o_cipher       (o_cipher),
        .o_cipher_valid (o_cipher_valid)
    );

    assign o_rotor_pos_0 = rotor_pos[0];
    assign o_rotor_pos_1 = rotor_pos[1];
    assign o_rotor_pos_2 = rotor_pos[2];

endmodule

`default_nettype wire

// File: src/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    ////////////////////////////////////////////////////////////
    // keyboard byte stream
    ////////////////////////////////////////////////////////////

    // one decoded keyboard byte
    typedef logic [7:0] scan_code_t;

    // quiet-time counter after a release
    typedef logic [12:0] wait_cnt_t;

    // make / break / wait sequence of a single key
    typedef enum logic [2:0] {
        INIT  = 3'd0,
        IDLE  = 3'd1,
        MAKE  = 3'd2,
        BREAK = 3'd3,
        WAIT  = 3'd4
    } kbd_state_t;

    // prefix byte sent ahead of a released key
    localparam scan_code_t BREAK_CODE = 8'hF0;

    // quiet cycles once the step has been issued
    localparam wait_cnt_t WAIT_CYCLES = 13'd5000;

    // lookup result for any code that is not a letter key
    localparam logic [4:0] NOT_LETTER = 5'd31;

    ////////////////////////////////////////////////////////////
    // set 2 scan codes, entry i is the key of letter i (A..Z)
    ////////////////////////////////////////////////////////////
    localparam scan_code_t SCAN_TO_LETTER [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };

endpackage

`default_nettype wire

// File: src/key_event_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module key_event_fsm (
    input  wire                 CLOCK_50,
    input  wire                 i_rst_n,
    input  wire kbd_pkg::scan_code_t i_scan_code,
    input  wire                 i_scan_strobe,
    output enigma_pkg::letter_t o_letter,
    output logic                o_make,
    output logic                o_step
);

    kbd_pkg::kbd_state_t state;
    // code of the key being held, matched again on release
    kbd_pkg::scan_code_t held_code;
    kbd_pkg::wait_cnt_t  wait_cnt;
    enigma_pkg::letter_t key_idx;

    ////////////////////////////////////////////////////////////
    // scan code to letter index
    ////////////////////////////////////////////////////////////
    always_comb begin
        key_idx = kbd_pkg::NOT_LETTER;
        for (int i = 0; i < enigma_pkg::ALPHABET_SIZE; i++) begin
            if (i_scan_code == kbd_pkg::SCAN_TO_LETTER[i]) begin
                key_idx = enigma_pkg::letter_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // make / break / wait sequence
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= kbd_pkg::INIT;
            held_code <= '0;
            o_letter  <= '0;
            wait_cnt  <= '0;
            o_step    <= 1'b0;
        end else begin
            // step is a one-cycle pulse
            o_step <= 1'b0;
            case (state)
                kbd_pkg::INIT: begin
                    state <= kbd_pkg::IDLE;
                end
                kbd_pkg::IDLE: begin
                    // other keys dropped here
                    if (i_scan_strobe && key_idx != kbd_pkg::NOT_LETTER) begin
                        state     <= kbd_pkg::MAKE;
                        held_code <= i_scan_code;
                        o_letter  <= key_idx;
                    end
                end
                kbd_pkg::MAKE: begin
                    // repeats of the make code are ignored
                    if (i_scan_strobe && i_scan_code == kbd_pkg::BREAK_CODE) begin
                        state <= kbd_pkg::BREAK;
                    end
                end
                kbd_pkg::BREAK: begin
                    // release must name the same key
                    if (i_scan_strobe && i_scan_code == held_code) begin
                        state    <= kbd_pkg::WAIT;
                        o_step   <= 1'b1;
                        wait_cnt <= '0;
                    end
                end
                kbd_pkg::WAIT: begin
                    // WAIT_CYCLES+1 quiet cycles, strobes dropped
                    if (wait_cnt == kbd_pkg::WAIT_CYCLES) begin
                        state <= kbd_pkg::IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 13'd1;
                    end
                end
                default: begin
                    state <= kbd_pkg::IDLE;
                end
            endcase
        end
    end

    // cipher path encodes while the key is down
    assign o_make = (state == kbd_pkg::MAKE);

    // one step per release, never stretched
    a_step_pulse: assert property (
        @(posedge CLOCK_50) disable iff (!i_rst_n)
        o_step |=> !o_step && state == kbd_pkg::WAIT
    );

endmodule

`default_nettype wire

// File: src/rotor_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rotor_stage #(
    parameter int ROTOR_ID = 0
) (
    input  wire                 CLOCK_50,
    input  wire                 i_rst_n,
    input  wire                 i_step,
    input  wire                 i_load_en,
    input  wire enigma_pkg::letter_t i_load_letter,
    input  wire enigma_pkg::letter_t i_fwd,
    input  wire enigma_pkg::letter_t i_bwd,
    output enigma_pkg::letter_t o_fwd,
    output enigma_pkg::letter_t o_bwd,
    output logic                o_carry,
    output enigma_pkg::letter_t o_pos
);

    enigma_pkg::letter_t fwd_contact;
    enigma_pkg::letter_t bwd_contact;
    enigma_pkg::letter_t bwd_pin;

    // (a + b) mod 26
    function automatic enigma_pkg::letter_t add_mod(input enigma_pkg::letter_t a,
                                                    input enigma_pkg::letter_t b);
        logic [5:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= enigma_pkg::ALPHABET_SIZE) begin
            sum = sum - 6'(enigma_pkg::ALPHABET_SIZE);
        end
        return sum[4:0];
    endfunction

    // (a - b) mod 26, offset by 26 to stay positive
    function automatic enigma_pkg::letter_t sub_mod(input enigma_pkg::letter_t a,
                                                    input enigma_pkg::letter_t b);
        logic [5:0] diff;
        diff = {1'b0, a} + 6'(enigma_pkg::ALPHABET_SIZE) - {1'b0, b};
        if (diff >= enigma_pkg::ALPHABET_SIZE) begin
            diff = diff - 6'(enigma_pkg::ALPHABET_SIZE);
        end
        return diff[4:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // position register, load wins over step
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pos <= '0;
        end else if (i_load_en) begin
            // letters past Z are not taken
            if (i_load_letter < enigma_pkg::ALPHABET_SIZE) begin
                o_pos <= i_load_letter;
            end
        end else if (i_step) begin
            o_pos <= (o_pos == enigma_pkg::ALPHABET_SIZE - 1) ? '0 : o_pos + 5'd1;
        end
    end

    // carry leaves in the same cycle as the step that hits the notch
    assign o_carry = i_step && (o_pos == enigma_pkg::ROTOR_NOTCH[ROTOR_ID]);

    // right to left, shifted in by the position and back out
    always_comb begin
        fwd_contact = add_mod(i_fwd, o_pos);
        o_fwd = sub_mod(enigma_pkg::ROTOR_WIRING[ROTOR_ID][fwd_contact], o_pos);
    end

    // left to right, search the wiring for the inverse contact
    always_comb begin
        bwd_contact = add_mod(i_bwd, o_pos);
        bwd_pin = '0;
        for (int j = 0; j < enigma_pkg::ALPHABET_SIZE; j++) begin
            if (enigma_pkg::ROTOR_WIRING[ROTOR_ID][j] == bwd_contact) begin
                bwd_pin = enigma_pkg::letter_t'(j);
            end
        end
        o_bwd = sub_mod(bwd_pin, o_pos);
    end

    a_pos_range: assert property (
        @(posedge CLOCK_50) disable iff (!i_rst_n)
        o_pos < enigma_pkg::ALPHABET_SIZE
    );

endmodule

`default_nettype wire

// File: src/setting_sync.sv
`timescale 1ns/1ns
`default_nettype none

module setting_sync (
    input  wire                                  CLOCK_50,
    input  wire                                  i_rst_n,
    input  wire [enigma_pkg::NUM_ROTORS-1:0]     i_set_sel,
    input  wire enigma_pkg::letter_t             i_set_letter,
    input  wire                                  i_load_n,
    output logic [enigma_pkg::NUM_ROTORS-1:0]    o_load_en,
    output enigma_pkg::letter_t                  o_load_letter
);

    logic [enigma_pkg::NUM_ROTORS-1:0] sel_meta;
    logic [enigma_pkg::NUM_ROTORS-1:0] sel_sync;
    enigma_pkg::letter_t               letter_meta;
    logic                              load_n_meta;
    logic                              load_n_sync;
    logic                              sel_onehot;

    // two flops on every switch line, load idles high
    always_ff @(posedge CLOCK_50 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_meta      <= '0;
            sel_sync      <= '0;
            letter_meta   <= '0;
            o_load_letter <= '0;
            load_n_meta   <= 1'b1;
            load_n_sync   <= 1'b1;
        end else begin
            sel_meta      <= i_set_sel;
            sel_sync      <= sel_meta;
            letter_meta   <= i_set_letter;
            o_load_letter <= letter_meta;
            load_n_meta   <= i_load_n;
            load_n_sync   <= load_n_meta;
        end
    end

    // exactly one bit set, otherwise no rotor is chosen
    assign sel_onehot = (sel_sync != '0) && ((sel_sync & (sel_sync - 1'b1)) == '0);

    assign o_load_en = (sel_onehot && !load_n_sync) ? sel_sync : '0;

    // an enable needs a single rotor and a low load two edges back
    a_load_en: assert property (
        @(posedge CLOCK_50) disable iff (!i_rst_n)
        (o_load_en != '0) |-> ($onehot(o_load_en) && !$past(i_load_n, 2))
    );

endmodule

`default_nettype wire

// File: tb.f
src/kbd_pkg.sv
src/enigma_pkg.sv
src/key_event_fsm.sv
src/setting_sync.sv
src/rotor_stage.sv
src/cipher_output.sv
src/enigma_top.sv
test/tb_clock.sv
test/enigma_tb.sv

// File: test/enigma_tb.sv
`timescale 1ns/1ns
`default_nettype none

module enigma_tb;

    localparam int PERIOD_NS = 100;
    // notch letters of the right and middle rotors, V and E
    localparam int NOTCH_V = 21;
    localparam int NOTCH_E = 4;
    localparam int VALID_TIMEOUT = 10;
    localparam int RECIP_LEN = 8;
    // 1 known value, 5 stepping, 1 wrong break, 2 x RECIP_LEN reciprocity
    localparam int NUM_PRESSES = 7 + 2 * RECIP_LEN;
    localparam longint TIMEOUT_NS =
        longint'(NUM_PRESSES) * (kbd_pkg::WAIT_CYCLES + 40) * PERIOD_NS + 4000 * PERIOD_NS;

    logic                      CLOCK_50;
    logic                      rst_n;
    kbd_pkg::scan_code_t       scan_code;
    logic                      scan_strobe;
    logic [2:0]                set_sel;
    enigma_pkg::letter_t       set_letter;
    logic                      load_n;
    wire enigma_pkg::ascii_t   cipher;
    wire                       cipher_valid;
    wire enigma_pkg::letter_t  pos0;
    wire enigma_pkg::letter_t  pos1;
    wire enigma_pkg::letter_t  pos2;

    // reference state
    int                  exp_pos [3];
    enigma_pkg::letter_t pressed;
    logic [31:0]         lcg_state;
    int                  err_cnt;
    int                  check_cnt;
    int                  test_cnt;
    int                  bad_tests;

    tb_clock #(.PERIOD_NS(PERIOD_NS)) tb_clock_i (
        .o_clk   (CLOCK_50),
        .o_rst_n (rst_n)
    );

    enigma_top dut_i (
        .CLOCK_50       (CLOCK_50),
        .i_rst_n        (rst_n),
        .i_scan_code    (scan_code),
        .i_scan_strobe  (scan_strobe),
        .i_set_sel      (set_sel),
        .i_set_letter   (set_letter),
        .i_load_n       (load_n),
        .o_cipher       (cipher),
        .o_cipher_valid (cipher_valid),
        .o_rotor_pos_0  (pos0),
        .o_rotor_pos_1  (pos1),
        .o_rotor_pos_2  (pos2)
    );

    ////////////////////////////////////////////////////////////
    // cipher character rules, checked on every edge
    ////////////////////////////////////////////////////////////
    a_cipher_upper: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n)
        cipher_valid |-> (cipher >= 8'h41 && cipher <= 8'h5A)
    ) else begin
        $display("FAILED time=%0t o_cipher expected 41..5a actual %h", $time, $sampled(cipher));
        err_cnt++;
    end

    // an Enigma never maps a letter to itself
    a_cipher_not_plain: assert property (
        @(posedge CLOCK_50) disable iff (!rst_n)
        cipher_valid |-> (cipher != 8'h41 + 8'(pressed))
    ) else begin
        $display("FAILED time=%0t o_cipher expected not %h actual %h",
                 $time, 8'h41 + 8'($sampled(pressed)), $sampled(cipher));
        err_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_letter(output enigma_pkg::letter_t letter);
        lcg_state = lcg_next(lcg_state);
        letter = enigma_pkg::letter_t'(lcg_state[31:16] % 26);
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        check_cnt++;
        assert (exp == act) else begin
            $display("FAILED time=%0t %s expected %0d actual %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_positions();
        check_value("o_rotor_pos_0", exp_pos[0], pos0);
        check_value("o_rotor_pos_1", exp_pos[1], pos1);
        check_value("o_rotor_pos_2", exp_pos[2], pos2);
    endtask

    // plain odometer, carry taken from the position before the step
    task automatic advance_model();
        bit carry_1;
        bit carry_2;
        carry_1 = (exp_pos[0] == NOTCH_V);
        carry_2 = carry_1 && (exp_pos[1] == NOTCH_E);
        exp_pos[0] = (exp_pos[0] + 1) % 26;
        if (carry_1) begin
            exp_pos[1] = (exp_pos[1] + 1) % 26;
        end
        if (carry_2) begin
            exp_pos[2] = (exp_pos[2] + 1) % 26;
        end
    endtask

    // one-cycle strobe with the byte
    task automatic send_byte(input kbd_pkg::scan_code_t code);
        @(posedge CLOCK_50);
        scan_code   <= code;
        scan_strobe <= 1'b1;
        @(posedge CLOCK_50);
        scan_strobe <= 1'b0;
    endtask

    task automatic wait_valid(output logic ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (n < VALID_TIMEOUT && !ok) begin
            @(negedge CLOCK_50);
            ok = cipher_valid;
            n++;
        end
        if (!ok) begin
            $display("no cipher output within %0d cycles of a key press at %0t",
                     VALID_TIMEOUT, $time);
            err_cnt++;
        end
    endtask

    // make, F0, same code; optionally a wrong release first
    task automatic press_key(input enigma_pkg::letter_t letter, input bit wrong_break,
                             output enigma_pkg::ascii_t ctext);
        kbd_pkg::scan_code_t code;
        kbd_pkg::scan_code_t other;
        logic ok;
        code = kbd_pkg::SCAN_TO_LETTER[letter];
        other = kbd_pkg::SCAN_TO_LETTER[(int'(letter) + 1) % 26];
        pressed = letter;
        send_byte(code);
        wait_valid(ok);
        ctext = cipher;
        send_byte(kbd_pkg::BREAK_CODE);
        if (wrong_break) begin
            send_byte(other);
            repeat (4) @(negedge CLOCK_50);
            check_value("o_cipher_valid", 0, cipher_valid);
            check_positions();
        end
        send_byte(code);
        // step pulse, position update, then the quiet time
        repeat (kbd_pkg::WAIT_CYCLES + 4) @(negedge CLOCK_50);
        advance_model();
        check_positions();
        check_value("o_cipher_valid", 0, cipher_valid);
        check_value("o_cipher", 0, cipher);
    endtask

    // settings pass two flops, so hold each level a few edges
    task automatic load_rotor(input logic [2:0] sel, input enigma_pkg::letter_t letter);
        @(posedge CLOCK_50);
        set_sel    <= sel;
        set_letter <= letter;
        load_n     <= 1'b0;
        repeat (4) @(posedge CLOCK_50);
        load_n <= 1'b1;
        repeat (3) @(posedge CLOCK_50);
        set_sel <= '0;
        @(negedge CLOCK_50);
        if (sel == 3'b001) begin
            exp_pos[0] = letter;
        end else if (sel == 3'b010) begin
            exp_pos[1] = letter;
        end else if (sel == 3'b100) begin
            exp_pos[2] = letter;
        end
        check_positions();
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("%-14s passed", name);
        end else begin
            bad_tests++;
            $display("%-14s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        enigma_pkg::letter_t plain [RECIP_LEN];
        enigma_pkg::ascii_t  ctext_q [RECIP_LEN];
        enigma_pkg::letter_t setting [3];
        enigma_pkg::letter_t letter;
        enigma_pkg::ascii_t  ctext;
        int                  err_before;
        scan_code   = '0;
        scan_strobe = 1'b0;
        set_sel     = '0;
        set_letter  = '0;
        load_n      = 1'b1;
        pressed     = '0;
        lcg_state   = 32'ha164;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        bad_tests   = 0;
        exp_pos     = '{0, 0, 0};

        // reset state
        wait (rst_n === 1'b1);
        @(negedge CLOCK_50);
        err_before = err_cnt;
        check_positions();
        check_value("o_cipher_valid", 0, cipher_valid);
        check_value("o_cipher", 0, cipher);
        report_test("reset_state", err_before);

        // AAA, key A gives U, rotors step only after the release
        err_before = err_cnt;
        press_key(5'd0, 1'b0, ctext);
        check_value("o_cipher", 8'h55, ctext);
        report_test("known_value", err_before);

        // one-hot selects load, others do nothing
        err_before = err_cnt;
        load_rotor(3'b001, 5'd19);
        load_rotor(3'b010, 5'd3);
        load_rotor(3'b100, 5'd10);
        load_rotor(3'b011, 5'd7);
        load_rotor(3'b000, 5'd7);
        load_rotor(3'b111, 5'd7);
        report_test("loading", err_before);

        // T..X on the right rotor, carry into the middle at V
        err_before = err_cnt;
        repeat (4) begin
            next_letter(letter);
            press_key(letter, 1'b0, ctext);
        end
        // V and E together, double carry
        load_rotor(3'b001, 5'd21);
        next_letter(letter);
        press_key(letter, 1'b0, ctext);
        report_test("stepping", err_before);

        // space key in idle, then a release naming another key
        err_before = err_cnt;
        send_byte(8'h29);
        repeat (4) @(negedge CLOCK_50);
        check_value("o_cipher_valid", 0, cipher_valid);
        check_positions();
        next_letter(letter);
        press_key(letter, 1'b1, ctext);
        report_test("ignored_keys", err_before);

        ////////////////////////////////////////////////////////////
        // reciprocity, same setting decrypts the ciphertext
        ////////////////////////////////////////////////////////////
        err_before = err_cnt;
        for (int i = 0; i < 3; i++) begin
            next_letter(setting[i]);
            load_rotor(3'(1 << i), setting[i]);
        end
        for (int n = 0; n < RECIP_LEN; n++) begin
            next_letter(plain[n]);
            press_key(plain[n], 1'b0, ctext_q[n]);
        end
        for (int i = 0; i < 3; i++) begin
            load_rotor(3'(1 << i), setting[i]);
        end
        for (int n = 0; n < RECIP_LEN; n++) begin
            press_key(enigma_pkg::letter_t'(ctext_q[n] - 8'h41), 1'b0, ctext);
            check_value("o_cipher", 8'h41 + 8'(plain[n]), ctext);
        end
        report_test("reciprocity", err_before);

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 test_cnt, bad_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run length bounded by the number of key presses
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests completed");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk,
    output logic o_rst_n
);

    // free-running clock
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset low for two cycles, released on a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
